/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_cam_cfg
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/cam_cfg_table.svh */
// Sensor register settings, one write per entry
// Entry layout is {device address, register address, data}
// Included inside a module body, so every user gets its own copy

localparam int CAM_CFG_TABLE_SIZE = 26;

localparam logic [31:0] CAM_CFG_TABLE [CAM_CFG_TABLE_SIZE] = '{
    32'h78_3008_82, // Soft reset
    32'h78_3008_42, // Power down while loading
    32'h78_3103_03, // Clock from PLL
    32'h78_3017_ff, // Pad output enables
    32'h78_3018_ff,
    32'h78_3034_1a, // MIPI 10 bit mode
    32'h78_3037_13, // PLL root divider
    32'h78_3108_01, // System root divider
    32'h78_3630_36,
    32'h78_3631_0e,
    32'h78_3632_e2,
    32'h78_3633_12,
    32'h78_3621_e0,
    32'h78_3704_a0,
    32'h78_3703_5a,
    32'h78_3715_78,
    32'h78_3717_01,
    32'h78_370b_60,
    32'h78_3705_1a,
    32'h78_3905_02,
    32'h78_3906_10,
    32'h78_3901_0a,
    32'h78_3731_12,
    32'h78_3600_08, // VCM control
    32'h78_3601_33,
    32'h78_3008_02  // Wake up
};

/* source/cam_cfg_apb_regs.sv */
`timescale 1ns/1ps

module cam_cfg_apb_regs
    import cam_cfg_pkg::*;
#(
    parameter int CONFIG_DEPTH = 26
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    input  logic        busy,
    input  logic        done,
    input  logic        error,
    input  logic [7:0]  completed,
    input  logic [7:0]  fail_index,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        start,
    output logic [7:0]  count,
    output logic [15:0] prescale
);

    logic access;
    logic wr_en;
    logic mapped;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign mapped = (paddr == REG_CTRL)     || (paddr == REG_STATUS) ||
                    (paddr == REG_COUNT)    || (paddr == REG_PRESCALE) ||
                    (paddr == REG_PROGRESS);

    assign pready  = 1'b1;                // No wait states
    assign pslverr = access && !mapped;

    //////////////////////////////
    // Writes

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start    <= 1'b0;
            count    <= 8'(CONFIG_DEPTH);
            prescale <= PRESCALE_RESET;
        end else begin
            // One cycle pulse, dropped while a run is active
            start <= wr_en && (paddr == REG_CTRL) && pwdata[0] && !busy;
            if (wr_en && paddr == REG_COUNT) begin
                count <= pwdata[7:0];
            end
            if (wr_en && paddr == REG_PRESCALE) begin
                prescale <= (pwdata[15:0] == 16'd0) ? 16'd1 : pwdata[15:0];
            end
        end
    end

    //////////////////////////////
    // Read mux

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_STATUS:   prdata = {29'd0, error, done, busy};
            REG_COUNT:    prdata = {24'd0, count};
            REG_PRESCALE: prdata = {16'd0, prescale};
            REG_PROGRESS: prdata = {16'd0, fail_index, completed};
            default:      prdata = '0;  // CTRL reads as zero
        endcase
    end

endmodule

/* source/cam_cfg_pkg.sv */
package cam_cfg_pkg;

    //////////////////////////////
    // FSM encodings

    typedef enum logic [2:0] {
        SEQ_IDLE  = 3'd0,
        SEQ_FETCH = 3'd1,   // ROM address presented
        SEQ_WRITE = 3'd2,   // ROM data valid, launch bus write
        SEQ_WAIT  = 3'd3,   // Waiting on master done
        SEQ_DONE  = 3'd4,
        SEQ_ERROR = 3'd5
    } seq_state_e;

    typedef enum logic [2:0] {
        BUS_IDLE  = 3'd0,
        BUS_START = 3'd1,
        BUS_BIT   = 3'd2,   // One data bit per slot
        BUS_ACK   = 3'd3,   // Ninth clock, slave drives SDA
        BUS_STOP  = 3'd4
    } bus_state_e;

    //////////////////////////////
    // APB register map

    localparam logic [7:0] REG_CTRL     = 8'h00; // Bit 0 start, write 1
    localparam logic [7:0] REG_STATUS   = 8'h04; // Busy, done, error
    localparam logic [7:0] REG_COUNT    = 8'h08;
    localparam logic [7:0] REG_PRESCALE = 8'h0C; // Quarter SCL period in clk cycles
    localparam logic [7:0] REG_PROGRESS = 8'h10; // Fail index and entries done

    localparam logic [15:0] PRESCALE_RESET = 16'd4;

endpackage

/* source/cam_cfg_rom.sv */
`timescale 1ns/1ps

module cam_cfg_rom #(
    parameter  int CONFIG_DEPTH = 26,
    localparam int ADDR_W       = (CONFIG_DEPTH > 1) ? $clog2(CONFIG_DEPTH) : 1
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] rom_addr,
    output logic [31:0]       entry
);

    `include "cam_cfg_table.svh"

    logic addr_ok;

    // Addresses past the used depth read as zero
    assign addr_ok = int'(rom_addr) < CONFIG_DEPTH;

    //////////////////////////////
    // Synchronous read port

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            entry <= CAM_CFG_TABLE[rom_addr];
        end else begin
            entry <= '0;
        end
    end

endmodule

/* source/cam_cfg_sequencer.sv */
`timescale 1ns/1ps

module cam_cfg_sequencer
    import cam_cfg_pkg::*;
#(
    parameter  int CONFIG_DEPTH = 26,
    localparam int ADDR_W       = (CONFIG_DEPTH > 1) ? $clog2(CONFIG_DEPTH) : 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [7:0]        count,
    input  logic [31:0]       entry,
    input  logic              bus_done,
    input  logic              bus_nack,
    output logic [ADDR_W-1:0] rom_addr,
    output logic              write,
    output logic [7:0]        dev_addr,
    output logic [15:0]       reg_addr,
    output logic [7:0]        wr_data,
    output logic              busy,
    output logic              done,
    output logic              error,
    output logic [7:0]        completed,
    output logic [7:0]        fail_index
);

    localparam logic [7:0] DEPTH_8 = 8'(CONFIG_DEPTH);

    seq_state_e        state;
    logic [ADDR_W-1:0] index;
    logic [7:0]        limit;   // Count clamped to the table depth

    // Index stays put through the write, so the fields hold too
    assign rom_addr = index;
    assign dev_addr = entry[31:24];
    assign reg_addr = entry[23:8];
    assign wr_data  = entry[7:0];

    assign busy  = (state == SEQ_FETCH) || (state == SEQ_WRITE) || (state == SEQ_WAIT);
    assign done  = (state == SEQ_DONE);
    assign error = (state == SEQ_ERROR);

    //////////////////////////////
    // Table walk

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= SEQ_IDLE;
            index      <= '0;
            limit      <= '0;
            completed  <= '0;
            fail_index <= '0;
            write      <= 1'b0;
        end else begin
            write <= 1'b0;
            case (state)
                SEQ_IDLE, SEQ_DONE, SEQ_ERROR: begin
                    if (start) begin    // Also clears done and error
                        index      <= '0;
                        completed  <= '0;
                        fail_index <= '0;
                        limit      <= (count > DEPTH_8) ? DEPTH_8 : count;
                        state      <= (count == 8'd0) ? SEQ_DONE : SEQ_FETCH;
                    end
                end
                SEQ_FETCH: begin
                    state <= SEQ_WRITE;     // ROM registers the entry
                end
                SEQ_WRITE: begin
                    write <= 1'b1;
                    state <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    if (bus_done) begin
                        if (bus_nack) begin
                            fail_index <= completed;
                            state      <= SEQ_ERROR;
                        end else begin
                            completed <= completed + 8'd1;
                            index     <= index + 1'b1;
                            if (completed + 8'd1 == limit) begin
                                state <= SEQ_DONE;
                            end else begin
                                state <= SEQ_FETCH;
                            end
                        end
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/cam_cfg_top.sv */
`timescale 1ns/1ps

module cam_cfg_top #(
    parameter int CONFIG_DEPTH = 26
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        scl_oe,
    output logic        sda_oe,
    input  logic        sda_in
);

    localparam int ADDR_W = (CONFIG_DEPTH > 1) ? $clog2(CONFIG_DEPTH) : 1;

    // Register block side
    logic        start;
    logic [7:0]  count;
    logic [15:0] prescale;
    logic        busy;
    logic        done;
    logic        error;
    logic [7:0]  completed;
    logic [7:0]  fail_index;

    // Table and bus write side
    logic [ADDR_W-1:0] rom_addr;
    logic [31:0]       entry;
    logic              write;
    logic [7:0]        dev_addr;
    logic [15:0]       reg_addr;
    logic [7:0]        wr_data;
    logic              bus_done;
    logic              bus_nack;

    cam_cfg_apb_regs #(.CONFIG_DEPTH(CONFIG_DEPTH)) u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .busy       (busy),
        .done       (done),
        .error      (error),
        .completed  (completed),
        .fail_index (fail_index),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .start      (start),
        .count      (count),
        .prescale   (prescale)
    );

    cam_cfg_sequencer #(.CONFIG_DEPTH(CONFIG_DEPTH)) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .count      (count),
        .entry      (entry),
        .bus_done   (bus_done),
        .bus_nack   (bus_nack),
        .rom_addr   (rom_addr),
        .write      (write),
        .dev_addr   (dev_addr),
        .reg_addr   (reg_addr),
        .wr_data    (wr_data),
        .busy       (busy),
        .done       (done),
        .error      (error),
        .completed  (completed),
        .fail_index (fail_index)
    );

    cam_cfg_rom #(.CONFIG_DEPTH(CONFIG_DEPTH)) u_rom (
        .clk      (clk),
        .rom_addr (rom_addr),
        .entry    (entry)
    );

    sccb_write_master u_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .prescale (prescale),
        .write    (write),
        .dev_addr (dev_addr),
        .reg_addr (reg_addr),
        .wr_data  (wr_data),
        .sda_in   (sda_in),
        .scl_oe   (scl_oe),
        .sda_oe   (sda_oe),
        .done     (bus_done),
        .nack     (bus_nack)
    );

endmodule

/* source/sccb_write_master.sv */
`timescale 1ns/1ps

module sccb_write_master
    import cam_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] prescale,
    input  logic        write,
    input  logic [7:0]  dev_addr,
    input  logic [15:0] reg_addr,
    input  logic [7:0]  wr_data,
    input  logic        sda_in,
    output logic        scl_oe,     // High pulls SCL low
    output logic        sda_oe,     // High pulls SDA low
    output logic        done,
    output logic        nack
);

    bus_state_e  state;
    logic [15:0] tick_cnt;
    logic        tick;
    logic [1:0]  phase;        // Quarter within the current slot
    logic        slot_end;
    logic [31:0] shift;
    logic [2:0]  bit_cnt;
    logic [1:0]  byte_cnt;
    logic        ack_err;
    logic        scl_pull;
    logic        sda_pull;

    //////////////////////////////
    // Quarter period timebase

    assign tick = (state != BUS_IDLE) &&
                  ((prescale <= 16'd1) || (tick_cnt >= prescale - 16'd1));
    assign slot_end = tick && (phase == 2'd3);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            phase    <= '0;
        end else if (state == BUS_IDLE) begin
            tick_cnt <= '0;
            phase    <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
            phase    <= phase + 2'd1;  // Wraps into the next slot
        end else begin
            tick_cnt <= tick_cnt + 16'd1;
        end
    end

    //////////////////////////////
    // Slot sequencing

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= BUS_IDLE;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            ack_err  <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                BUS_IDLE: begin
                    if (write) begin
                        state    <= BUS_START;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                        ack_err  <= 1'b0;
                    end
                end
                BUS_START: begin
                    if (slot_end) state <= BUS_BIT;
                end
                BUS_BIT: begin
                    if (slot_end) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) state <= BUS_ACK;
                    end
                end
                BUS_ACK: begin
                    if (tick && phase == 2'd2) ack_err <= sda_in;  // Mid SCL high
                    if (slot_end) begin
                        if (ack_err || byte_cnt == 2'd3) begin
                            state <= BUS_STOP;   // Last byte or first NACK
                        end else begin
                            byte_cnt <= byte_cnt + 2'd1;
                            state    <= BUS_BIT;
                        end
                    end
                end
                BUS_STOP: begin
                    if (slot_end) begin
                        done  <= 1'b1;
                        nack  <= ack_err;
                        state <= BUS_IDLE;
                    end
                end
                default: begin
                    state <= BUS_IDLE;
                end
            endcase
        end
    end

    // Four bytes, MSB first
    always_ff @(posedge clk) begin
        if (state == BUS_IDLE && write) begin
            shift <= {dev_addr, reg_addr, wr_data};
        end else if (state == BUS_BIT && slot_end) begin
            shift <= shift << 1;
        end
    end

    //////////////////////////////
    // Line drive per quarter

    always_comb begin
        scl_pull = 1'b0;
        sda_pull = 1'b0;
        case (state)
            BUS_START: begin
                scl_pull = (phase == 2'd3);
                sda_pull = (phase != 2'd0);    // SDA falls with SCL high
            end
            BUS_BIT: begin
                scl_pull = (phase == 2'd0) || (phase == 2'd3);
                sda_pull = ~shift[31];
            end
            BUS_ACK: begin
                scl_pull = (phase == 2'd0) || (phase == 2'd3);
            end
            BUS_STOP: begin
                scl_pull = (phase == 2'd0);
                sda_pull = (phase <= 2'd1);    // SDA rises with SCL high
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scl_oe <= 1'b0;
            sda_oe <= 1'b0;
        end else begin
            scl_oe <= scl_pull;
            sda_oe <= sda_pull;
        end
    end

endmodule

/* sources.f */
+incdir+include
source/cam_cfg_pkg.sv
source/cam_cfg_rom.sv
source/cam_cfg_sequencer.sv
source/sccb_write_master.sv
source/cam_cfg_apb_regs.sv
source/cam_cfg_top.sv
tests/sccb_slave_model.sv
tests/cam_cfg_asserts.sv
tests/tb_cam_cfg.sv

/* tests/cam_cfg_asserts.sv */
`timescale 1ns/1ps

module cam_cfg_asserts
    import cam_cfg_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       pready,
    input logic       start,
    input logic       busy,
    input logic       scl_oe,
    input logic       sda_oe,
    input bus_state_e bus_state
);

    int failures = 0;   // Read by the testbench at the end

    // APB slave with no wait states
    pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else begin
            failures++;
            $error("pready went low");
        end

    start_not_busy: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else begin
            failures++;
            $error("start pulsed while busy");
        end

    // Line drive lags the state by one clock
    sda_stable_scl_high: assert property (@(posedge clk) disable iff (!rst_n)
        ($changed(sda_oe) && !scl_oe && !$past(scl_oe))
            |-> ($past(bus_state) inside {BUS_START, BUS_STOP}))
        else begin
            failures++;
            $error("SDA moved while SCL high outside START or STOP");
        end

endmodule

bind cam_cfg_top cam_cfg_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .pready    (pready),
    .start     (start),
    .busy      (busy),
    .scl_oe    (scl_oe),
    .sda_oe    (sda_oe),
    .bus_state (u_master.state)
);

/* tests/sccb_slave_model.sv */
`timescale 1ns/1ps

module sccb_slave_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        scl,
    input  logic        sda,
    input  logic        nack_enable,
    input  logic [15:0] nack_entry,    // Running entry number to refuse
    output logic        sda_pull       // High pulls SDA low
);

    logic [31:0] rx_entry [128];       // Entries in arrival order
    int          rx_count;
    int          start_count;
    logic        scl_q;
    logic        sda_q;
    logic [7:0]  shreg;
    logic [31:0] word;
    int          clk_cnt;              // SCL rises seen in this byte
    int          byte_cnt;

    //////////////////////////////
    // Line edges sampled on clk

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            sda_pull    <= 1'b0;
            shreg       <= '0;
            word        <= '0;
            clk_cnt     <= 0;
            byte_cnt    <= 0;
            rx_count    <= 0;
            start_count <= 0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda) begin
                // START condition
                start_count <= start_count + 1;
                clk_cnt     <= 0;
                byte_cnt    <= 0;
                sda_pull    <= 1'b0;
            end else if (scl && !scl_q) begin
                if (clk_cnt < 8) shreg <= {shreg[6:0], sda};  // MSB first
                clk_cnt <= clk_cnt + 1;
            end else if (!scl && scl_q) begin
                if (clk_cnt == 8) begin
                    word     <= {word[23:0], shreg};
                    byte_cnt <= byte_cnt + 1;
                    if (byte_cnt == 3) begin
                        rx_entry[rx_count] <= {word[23:0], shreg};
                        rx_count           <= rx_count + 1;
                    end
                    // ACK unless this entry is the one to refuse
                    sda_pull <= !(nack_enable && rx_count == int'(nack_entry));
                end else if (clk_cnt == 9) begin
                    sda_pull <= 1'b0;   // Ninth clock over
                    clk_cnt  <= 0;
                end
            end
        end
    end

endmodule

/* tests/tb_cam_cfg.sv */
`timescale 1ns/1ps

module tb_cam_cfg
    import cam_cfg_pkg::*;
();

    `include "cam_cfg_table.svh"

    localparam int DEPTH           = 26;
    localparam int SLOTS_PER_ENTRY = 38;    // START, 4 bytes of 9 slots, STOP
    localparam int CLK_NS          = 40;
    // Twice three full runs at prescale 4 plus one short run at prescale 2
    localparam longint WATCHDOG_NS =
        2 * (3 * DEPTH * SLOTS_PER_ENTRY * 4 * 4 + 5 * SLOTS_PER_ENTRY * 4 * 2) * CLK_NS;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl_oe;
    logic        sda_oe;
    logic        slave_pull;
    logic        scl_line;
    logic        sda_line;
    logic        nack_enable;
    logic [15:0] nack_entry;
    int          errors;
    int          checks;
    int          seed = 32'h471f;

    assign scl_line = ~scl_oe;                 // Pull-ups on both lines
    assign sda_line = ~(sda_oe | slave_pull);  // Wired AND

    cam_cfg_top #(.CONFIG_DEPTH(DEPTH)) dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl_oe  (scl_oe),
        .sda_oe  (sda_oe),
        .sda_in  (sda_line)
    );

    sccb_slave_model responder (
        .clk         (clk),
        .rst_n       (rst_n),
        .scl         (scl_line),
        .sda         (sda_line),
        .nack_enable (nack_enable),
        .nack_entry  (nack_entry),
        .sda_pull    (slave_pull)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // APB access

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        data = prdata;     // Value held through the access phase
        err  = pslverr;
        check_word("pready", {31'd0, pready}, 32'h1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    //////////////////////////////
    // Compare tasks

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_entry(input int idx, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: entry %0d = 0x%08h, expected 0x%08h", idx, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_received(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            check_entry(i, responder.rx_entry[base + i], CAM_CFG_TABLE[i]);
        end
    endtask

    // Poll STATUS until busy drops
    task automatic wait_idle(input int entries, input int pre);
        logic [31:0] status;
        logic        err;
        int          polls;
        int          limit;
        limit  = entries * SLOTS_PER_ENTRY * 4 * pre + 16;   // Three clocks per read
        polls  = 0;
        status = 32'h1;
        while (status[0] && polls < limit) begin
            apb_read(REG_STATUS, status, err);
            polls++;
        end
        if (status[0]) begin
            errors++;
            $display("Run still busy after %0d status reads", polls);
        end
    endtask

    task automatic check_success(input int base, input int n);
        logic [31:0] rd;
        logic        err;
        apb_read(REG_STATUS, rd, err);
        check_word("STATUS", rd, 32'h2);
        apb_read(REG_PROGRESS, rd, err);
        check_word("PROGRESS", rd, 32'(n));
        check_count("entries received", responder.rx_count - base, n);
        check_received(base, n);
    endtask

    //////////////////////////////
    // Directed tests

    task automatic test_register_access();
        logic [31:0] rd;
        logic        err;
        apb_read(REG_STATUS, rd, err);
        check_word("STATUS", rd, 32'h0);
        apb_read(REG_COUNT, rd, err);
        check_word("COUNT", rd, 32'(DEPTH));
        apb_read(REG_PRESCALE, rd, err);
        check_word("PRESCALE", rd, 32'd4);
        check_word("pslverr", {31'd0, err}, 32'h0);
        apb_write(REG_COUNT, 32'd9);
        apb_read(REG_COUNT, rd, err);
        check_word("COUNT", rd, 32'd9);
        apb_write(REG_PRESCALE, 32'h0000_0123);
        apb_read(REG_PRESCALE, rd, err);
        check_word("PRESCALE", rd, 32'h0000_0123);
        apb_write(REG_PRESCALE, 32'h0);    // Zero reads back as one
        apb_read(REG_PRESCALE, rd, err);
        check_word("PRESCALE", rd, 32'h1);
        apb_read(8'h20, rd, err);
        check_word("pslverr", {31'd0, err}, 32'h1);
        apb_write(REG_COUNT, 32'(DEPTH));
        apb_write(REG_PRESCALE, 32'd4);
    endtask

    task automatic test_full_run();
        logic [31:0] rd;
        logic        err;
        int          base;
        base = responder.rx_count;
        apb_write(REG_CTRL, 32'h1);
        apb_read(REG_STATUS, rd, err);
        check_word("STATUS", rd, 32'h1);
        wait_idle(DEPTH, 4);
        check_success(base, DEPTH);
    endtask

    task automatic test_short_run();
        int base;
        base = responder.rx_count;
        apb_write(REG_COUNT, 32'd5);
        apb_write(REG_PRESCALE, 32'd2);
        apb_write(REG_CTRL, 32'h1);
        wait_idle(5, 2);
        check_success(base, 5);
        apb_write(REG_COUNT, 32'(DEPTH));
        apb_write(REG_PRESCALE, 32'd4);
    endtask

    task automatic test_nack();
        logic [31:0] rd;
        logic [31:0] r;
        logic        err;
        int          base;
        int          starts;
        int          k;
        r      = $random(seed);
        k      = int'(r % 32'd26);
        base   = responder.rx_count;
        starts = responder.start_count;
        @(negedge clk);
        nack_entry  = 16'(base + k);
        nack_enable = 1'b1;
        apb_write(REG_CTRL, 32'h1);
        wait_idle(k + 1, 4);
        apb_read(REG_STATUS, rd, err);
        check_word("STATUS", rd, 32'h4);
        apb_read(REG_PROGRESS, rd, err);
        check_word("PROGRESS", rd, {16'd0, 8'(k), 8'(k)});
        check_count("entries received", responder.rx_count - base, k);
        check_count("transfers started", responder.start_count - starts, k + 1);
        check_received(base, k);
        @(negedge clk);
        nack_enable = 1'b0;
    endtask

    task automatic test_restart();
        logic [31:0] rd;
        logic        err;
        int          base;
        int          polls;
        base = responder.rx_count;
        apb_write(REG_CTRL, 32'h1);
        apb_read(REG_STATUS, rd, err);
        check_word("STATUS", rd, 32'h1);   // Error flag gone
        polls = 0;
        rd    = 32'h0;
        while (rd[7:0] < 8'd2 && polls < 3 * SLOTS_PER_ENTRY * 4 * 4) begin
            apb_read(REG_PROGRESS, rd, err);
            polls++;
        end
        apb_write(REG_CTRL, 32'h1);        // Lands mid run
        apb_read(REG_PROGRESS, rd, err);
        if (rd[7:0] < 8'd2) begin
            errors++;
            $display("Start written while busy restarted the entry count");
        end
        wait_idle(DEPTH, 4);
        check_success(base, DEPTH);
    endtask

    //////////////////////////////
    // Main sequence and watchdog

    initial begin
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        nack_enable = 1'b0;
        nack_entry  = '0;
        errors      = 0;
        checks      = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_register_access();
        test_full_run();
        test_short_run();
        test_nack();
        test_restart();
        errors = errors + dut.u_asserts.failures;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule
